// ==== sources.f ====
source/risc8_pkg.sv
source/risc8_issue_if.sv
source/risc8_decode.sv
source/risc8_regfile.sv
source/risc8_alu.sv
source/risc8_retire.sv
source/risc8_core.sv
sim/risc8_properties.sv
sim/risc8_tb.sv

// ==== Bender.yml ====
package:
  name: risc8_lite

sources:
  - source/risc8_pkg.sv
  - source/risc8_issue_if.sv
  - source/risc8_decode.sv
  - source/risc8_regfile.sv
  - source/risc8_alu.sv
  - source/risc8_retire.sv
  - source/risc8_core.sv
  - target: simulation
    files:
      - sim/risc8_properties.sv
      - sim/risc8_tb.sv

// ==== sim/risc8_tb.sv ====
`default_nettype none

module risc8_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROM_WORDS = 4096;
	localparam int MAX_STORES = 1024;
	localparam int DRAIN_CYCLES = 20;

	logic clk;
	logic reset;
	risc8_pkg::pc_t pc;
	risc8_pkg::opcode_t cdata;
	risc8_pkg::addr_t data_addr;
	logic data_wen;
	risc8_pkg::byte_t data_write;

	risc8_pkg::opcode_t rom [ROM_WORDS];
	// expected stores in program order
	risc8_pkg::addr_t exp_addr [MAX_STORES];
	risc8_pkg::byte_t exp_data [MAX_STORES];
	int exp_count;
	int seen;
	int errors;
	int wp;
	int cycles;
	int limit;
	logic [31:0] rng;
	risc8_pkg::addr_t st_addr;

	risc8_core dut0 (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_write(data_write)
	);

	// combinational program ROM with NOP past the end
	assign cdata = (int'(pc) < ROM_WORDS) ? rom[pc[11:0]] : 16'h0000;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// one draw from the generator in 0 .. n-1
	function automatic int rand_below(input int n);
		rng = xorshift(rng);
		return int'(rng % 32'(n));
	endfunction

	// Rd Rr pair ops from their base opcode
	function automatic risc8_pkg::opcode_t rr_op(input risc8_pkg::opcode_t base,
			input int d, input int r);
		return base | 16'((r & 16) << 5) | 16'(d << 4) | 16'(r & 15);
	endfunction

	// K and r16..r31 ops including LDI
	function automatic risc8_pkg::opcode_t imm_op(input risc8_pkg::opcode_t base,
			input int d, input int k);
		return base | 16'((k & 240) << 4) | 16'((d - 16) << 4) | 16'(k & 15);
	endfunction

	function automatic risc8_pkg::opcode_t unary_op(input int code, input int d);
		return 16'h9400 | 16'(d << 4) | 16'(code);
	endfunction

	function automatic risc8_pkg::opcode_t rjmp_op(input int off);
		return 16'hc000 | 16'(off & 12'hfff);
	endfunction

	// clr picks BRBC over BRBS
	function automatic risc8_pkg::opcode_t branch_op(input int clr, input int b, input int off);
		return 16'hf000 | (clr != 0 ? 16'h0400 : 16'h0000) | 16'((off & 127) << 3) | 16'(b);
	endfunction

	function automatic risc8_pkg::opcode_t rr_base(input int i);
		case (i)
		0: return 16'h0c00; // ADD
		1: return 16'h1c00; // ADC
		2: return 16'h1800; // SUB
		3: return 16'h0800; // SBC
		4: return 16'h2000; // AND
		5: return 16'h2800; // OR
		6: return 16'h2400; // EOR
		7: return 16'h2c00; // MOV
		8: return 16'h1400; // CP
		default: return 16'h0400; // CPC
		endcase
	endfunction

	function automatic risc8_pkg::opcode_t imm_base(input int i);
		case (i)
		0: return 16'h3000; // CPI
		1: return 16'h4000; // SBCI
		2: return 16'h5000; // SUBI
		3: return 16'h6000; // ORI
		default: return 16'h7000; // ANDI
		endcase
	endfunction

	// COM NEG SWAP INC DEC ASR LSR ROR
	function automatic int unary_code(input int i);
		case (i)
		0: return 0;
		1: return 1;
		2: return 2;
		3: return 3;
		4: return 10;
		5: return 5;
		6: return 6;
		default: return 7;
		endcase
	endfunction

	task automatic put(input risc8_pkg::opcode_t w);
		rom[wp] = w;
		wp++;
	endtask

	// STS to the next free data address
	task automatic store_reg(input int r);
		put(16'h9200 | 16'(r << 4));
		put(st_addr);
		st_addr++;
	endtask

	// branch on every SREG bit into one of two store paths
	task automatic probe_flags(input int r);
		int clr;
		for (int b = 0; b < 8; b++) begin
			clr = rand_below(2);
			put(branch_op(clr, b, 3));
			store_reg(r);
			put(rjmp_op(2));
			store_reg(r);
		end
	endtask

	task automatic build_program();
		int prev;
		int d;
		int r;
		int sel;
		int k;
		wp = 0;
		st_addr = 16'h0100;
		for (int i = 0; i < ROM_WORDS; i++)
			rom[i] = 16'h0000;
		// constants into r16..r31 and each one stored back
		for (int i = 16; i < 32; i++) begin
			k = rand_below(256);
			put(imm_op(16'he000, i, k));
		end
		for (int i = 16; i < 32; i++)
			store_reg(i);
		// copy them into the low half
		for (int i = 0; i < 16; i++) begin
			r = 16 + rand_below(16);
			put(rr_op(16'h2c00, i, r));
		end
		// every pair op in turn on random registers with all flags exposed after each
		for (int i = 0; i < 16; i++) begin
			d = rand_below(32);
			sel = i % 10;
			r = rand_below(32);
			put(rr_op(rr_base(sel), d, r));
			probe_flags(d);
		end
		// carry chain ADD ADC ADC
		put(rr_op(16'h0c00, 2, 5));
		put(rr_op(16'h1c00, 3, 6));
		put(rr_op(16'h1c00, 4, 7));
		probe_flags(4);
		// CP equal then CPC keeps Z only while it stays zero
		put(rr_op(16'h1400, 8, 8));
		put(rr_op(16'h0400, 9, 9));
		probe_flags(9);
		put(rr_op(16'h1400, 10, 11));
		put(rr_op(16'h0400, 12, 12));
		probe_flags(12);
		// each immediate and single operand op in turn on fresh values
		for (int i = 0; i < 24; i++) begin
			d = 16 + rand_below(16);
			k = rand_below(256);
			put(imm_op(16'he000, d, k));
			sel = i % 13;
			k = rand_below(256);
			if (sel < 5)
				put(imm_op(imm_base(sel), d, k));
			else
				put(unary_op(unary_code(sel - 5), d));
			store_reg(d);
			probe_flags(d);
		end
		// rjmp over a store that never happens followed by a zero jump and NOPs
		put(rjmp_op(2));
		store_reg(0);
		put(rjmp_op(0));
		put(16'h0000);
		put(16'hffff);
		// with Z set BRBS skips its store and BRBC falls through to its store
		put(rr_op(16'h1400, 1, 1));
		put(branch_op(0, risc8_pkg::SREG_Z, 2));
		store_reg(1);
		put(branch_op(1, risc8_pkg::SREG_Z, 2));
		store_reg(1);
		store_reg(2);
		// back to back chain where each op uses the previous destination
		prev = rand_below(32);
		for (int i = 0; i < 24; i++) begin
			sel = rand_below(3);
			d = prev;
			if (sel == 2) begin
				k = rand_below(8);
				put(unary_op(unary_code(k), prev));
			end else begin
				r = rand_below(32);
				if (sel == 1) begin
					d = r;
					r = prev;
				end
				k = rand_below(10);
				put(rr_op(rr_base(k), d, r));
			end
			prev = d;
		end
		probe_flags(prev);
		for (int i = 0; i < 32; i++)
			store_reg(i);
		// park on rjmp -1
		put(16'hcfff);
	endtask

	// N Z S from the result with Z sticky for the carry compares
	function automatic void set_nzs(input risc8_pkg::byte_t res, input logic sticky,
			inout risc8_pkg::sreg_t s);
		s[risc8_pkg::SREG_N] = res[7];
		if (sticky)
			s[risc8_pkg::SREG_Z] = s[risc8_pkg::SREG_Z] & (res == 8'h00);
		else
			s[risc8_pkg::SREG_Z] = (res == 8'h00);
		s[risc8_pkg::SREG_S] = res[7] ^ s[risc8_pkg::SREG_V];
	endfunction

	// datasheet add equations
	function automatic void add_ref(input risc8_pkg::byte_t a, input risc8_pkg::byte_t b,
			input logic cin, inout risc8_pkg::sreg_t s, output risc8_pkg::byte_t res);
		res = a + b + 8'(cin);
		s[risc8_pkg::SREG_H] = (a[3] & b[3]) | (b[3] & ~res[3]) | (~res[3] & a[3]);
		s[risc8_pkg::SREG_C] = (a[7] & b[7]) | (b[7] & ~res[7]) | (~res[7] & a[7]);
		s[risc8_pkg::SREG_V] = (a[7] & b[7] & ~res[7]) | (~a[7] & ~b[7] & res[7]);
		set_nzs(res, 1'b0, s);
	endfunction

	// datasheet subtract equations with borrow in from cin
	function automatic void sub_ref(input risc8_pkg::byte_t a, input risc8_pkg::byte_t b,
			input logic cin, input logic sticky, inout risc8_pkg::sreg_t s,
			output risc8_pkg::byte_t res);
		res = a - b - 8'(cin);
		s[risc8_pkg::SREG_H] = (~a[3] & b[3]) | (b[3] & res[3]) | (res[3] & ~a[3]);
		s[risc8_pkg::SREG_C] = (~a[7] & b[7]) | (b[7] & res[7]) | (res[7] & ~a[7]);
		s[risc8_pkg::SREG_V] = (a[7] & ~b[7] & ~res[7]) | (~a[7] & b[7] & res[7]);
		set_nzs(res, sticky, s);
	endfunction

	// instruction level run of the ROM that fills the expected store list
	function automatic int run_reference();
		risc8_pkg::byte_t r [32];
		risc8_pkg::sreg_t s;
		risc8_pkg::opcode_t w;
		risc8_pkg::byte_t t;
		risc8_pkg::byte_t k;
		int pc_ref;
		int next;
		int n;
		int d;
		int rr;
		int di;
		int steps;
		for (int i = 0; i < 32; i++)
			r[i] = 8'h00;
		s = 8'h00;
		pc_ref = 0;
		n = 0;
		steps = 0;
		while (rom[pc_ref] != 16'hcfff && steps < ROM_WORDS) begin
			w = rom[pc_ref];
			d = int'(w[8:4]);
			rr = int'({w[9], w[3:0]});
			di = 16 + int'(w[7:4]);
			k = {w[11:8], w[3:0]};
			next = pc_ref + 1;
			case (w[15:12])
			4'h0, 4'h1, 4'h2: begin
				case (w[13:10])
				4'b0001: sub_ref(r[d], r[rr], s[risc8_pkg::SREG_C], 1'b1, s, t);
				4'b0010: begin
					sub_ref(r[d], r[rr], s[risc8_pkg::SREG_C], 1'b1, s, t);
					r[d] = t;
				end
				4'b0011, 4'b0111: begin
					// bit 12 picks ADC
					add_ref(r[d], r[rr], w[12] & s[risc8_pkg::SREG_C], s, t);
					r[d] = t;
				end
				4'b0110: begin
					sub_ref(r[d], r[rr], 1'b0, 1'b0, s, t);
					r[d] = t;
				end
				4'b0101: sub_ref(r[d], r[rr], 1'b0, 1'b0, s, t);
				4'b1000, 4'b1001, 4'b1010: begin
					if (w[13:10] == 4'b1000)
						t = r[d] & r[rr];
					else if (w[13:10] == 4'b1001)
						t = r[d] ^ r[rr];
					else
						t = r[d] | r[rr];
					s[risc8_pkg::SREG_V] = 1'b0;
					set_nzs(t, 1'b0, s);
					r[d] = t;
				end
				4'b1011: r[d] = r[rr];
				default: begin
					// NOP
				end
				endcase
			end
			4'h3: sub_ref(r[di], k, 1'b0, 1'b0, s, t);
			4'h4, 4'h5: begin
				// SBCI when the nibble is 4
				sub_ref(r[di], k, !w[12] & s[risc8_pkg::SREG_C], !w[12], s, t);
				r[di] = t;
			end
			4'h6, 4'h7: begin
				t = w[12] ? (r[di] & k) : (r[di] | k);
				s[risc8_pkg::SREG_V] = 1'b0;
				set_nzs(t, 1'b0, s);
				r[di] = t;
			end
			4'he: r[di] = k;
			4'h9: begin
				if (w[11:9] == 3'b001 && w[3:0] == 4'h0) begin
					// STS with the address in the next word
					if (n < MAX_STORES) begin
						exp_addr[n] = rom[pc_ref + 1];
						exp_data[n] = r[d];
					end
					n++;
					next = pc_ref + 2;
				end else if (w[11:9] == 3'b010) begin
					case (w[3:0])
					4'h0: begin
						t = ~r[d];
						s[risc8_pkg::SREG_V] = 1'b0;
						set_nzs(t, 1'b0, s);
						r[d] = t;
					end
					4'h1: begin
						sub_ref(8'h00, r[d], 1'b0, 1'b0, s, t);
						s[risc8_pkg::SREG_C] = (t != 8'h00);
						r[d] = t;
					end
					4'h2: r[d] = {r[d][3:0], r[d][7:4]};
					4'h3: begin
						add_ref(r[d], 8'h01, 1'b0, s, t);
						r[d] = t;
					end
					4'ha: begin
						sub_ref(r[d], 8'h01, 1'b0, 1'b0, s, t);
						r[d] = t;
					end
					4'h5, 4'h6, 4'h7: begin
						if (w[3:0] == 4'h5)
							t = {r[d][7], r[d][7:1]};
						else if (w[3:0] == 4'h6)
							t = {1'b0, r[d][7:1]};
						else
							t = {s[risc8_pkg::SREG_C], r[d][7:1]};
						s[risc8_pkg::SREG_C] = r[d][0];
						s[risc8_pkg::SREG_V] = t[7] ^ r[d][0];
						set_nzs(t, 1'b0, s);
						r[d] = t;
					end
					default: begin
						// NOP
					end
					endcase
				end
			end
			4'hc: next = pc_ref + 1 + int'($signed(w[11:0]));
			4'hf: begin
				// BRBS on bit 10 clear and BRBC on bit 10 set
				if (!w[11] && (w[10] ? !s[w[2:0]] : s[w[2:0]]))
					next = pc_ref + 1 + int'($signed(w[9:3]));
			end
			default: begin
				// NOP
			end
			endcase
			pc_ref = next;
			steps++;
		end
		return n;
	endfunction

	// store checker with one expected entry per strobe
	always @(posedge clk) begin
		if (!reset && data_wen) begin
			if (seen >= exp_count) begin
				$display("%0t: store to %h with %h when no store was expected",
					$time, data_addr, data_write);
				errors++;
			end else begin
				if (data_addr !== exp_addr[seen]) begin
					$display("FAILED %0t: store %0d address expected %h got %h",
						$time, seen, exp_addr[seen], data_addr);
					errors++;
				end
				if (data_write !== exp_data[seen]) begin
					$display("FAILED %0t: store %0d data expected %h got %h",
						$time, seen, exp_data[seen], data_write);
					errors++;
				end
				seen++;
			end
		end
	end

	initial begin
		reset = 1'b1;
		errors = 0;
		seen = 0;
		cycles = 0;
		rng = 32'd41;
		build_program();
		exp_count = run_reference();
		limit = 4 * wp + 50;
		// five reset cycles released on a falling edge
		repeat (5) begin
			@(negedge clk);
			if (data_wen !== 1'b0) begin
				$display("FAILED %0t: data_wen in reset expected 0 got %b", $time, data_wen);
				errors++;
			end
		end
		if (pc !== risc8_pkg::PC_RESET) begin
			$display("FAILED %0t: pc after reset expected %h got %h",
				$time, risc8_pkg::PC_RESET, pc);
			errors++;
		end
		reset = 1'b0;
		while (seen < exp_count && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (seen < exp_count) begin
			$display("timeout after %0d cycles, only %0d of %0d stores seen",
				cycles, seen, exp_count);
			errors++;
		end else begin
			// stray stores after the last expected one
			repeat (DRAIN_CYCLES) @(negedge clk);
		end
		$display("errors %0d, stores %0d of %0d", errors, seen, exp_count);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// ==== sim/risc8_properties.sv ====
`default_nettype none

module risc8_properties (
	input logic clk,
	input logic reset,
	input risc8_pkg::pc_t pc,
	input logic data_wen
);
	timeunit 1ns;
	timeprecision 1ps;

	// pc comes out of reset at the reset vector
	pc_after_reset: assert property (@(posedge clk) reset |=> pc == risc8_pkg::PC_RESET)
		else $error("pc not at the reset value after a reset cycle");

	// store strobe lasts one cycle
	wen_single_cycle: assert property (@(posedge clk) disable iff (reset)
		data_wen |=> !data_wen)
		else $error("data_wen high in two consecutive cycles");

	// no store strobe while reset is applied
	wen_low_in_reset: assert property (@(posedge clk) reset |=> !data_wen)
		else $error("data_wen high during reset");
endmodule

bind risc8_core risc8_properties props0 (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.data_wen(data_wen)
);

`default_nettype wire

// ==== source/risc8_core.sv ====
`default_nettype none

module risc8_core #(
	parameter int NUM_REGS = 32
) (
	input logic clk,
	input logic reset,
	output risc8_pkg::pc_t pc,
	input risc8_pkg::opcode_t cdata,
	output risc8_pkg::addr_t data_addr,
	output logic data_wen,
	output risc8_pkg::byte_t data_write
);
	risc8_pkg::reg_idx_t ra;
	risc8_pkg::reg_idx_t rb;
	risc8_pkg::byte_t rd_a;
	risc8_pkg::byte_t rd_b;
	risc8_pkg::sreg_t sreg;
	risc8_pkg::byte_t result;
	risc8_pkg::sreg_t next_sreg;
	logic wr_en;
	risc8_pkg::reg_idx_t wr_idx;
	risc8_pkg::byte_t wr_data;

	// decoded instruction, one per cycle
	risc8_issue_if issue_bus ();

	risc8_decode decode0 (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.pc(pc),
		.sreg(sreg),
		.ra(ra),
		.rb(rb),
		.issue(issue_bus.issue)
	);

	risc8_regfile #(
		.NUM_REGS(NUM_REGS)
	) regfile0 (
		.clk(clk),
		.reset(reset),
		.ra(ra),
		.rb(rb),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data)
	);

	risc8_alu alu0 (
		.rd_a(rd_a),
		.rd_b(rd_b),
		.sreg(sreg),
		.issue(issue_bus.exec),
		.result(result),
		.next_sreg(next_sreg)
	);

	risc8_retire retire0 (
		.clk(clk),
		.reset(reset),
		.issue(issue_bus.retire),
		.result(result),
		.next_sreg(next_sreg),
		.sreg(sreg),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_write(data_write)
	);
endmodule

`default_nettype wire

// ==== source/risc8_retire.sv ====
`default_nettype none

module risc8_retire (
	input logic clk,
	input logic reset,
	risc8_issue_if.retire issue,
	input risc8_pkg::byte_t result,
	input risc8_pkg::sreg_t next_sreg,
	output risc8_pkg::sreg_t sreg,
	output logic wr_en,
	output risc8_pkg::reg_idx_t wr_idx,
	output risc8_pkg::byte_t wr_data,
	output risc8_pkg::addr_t data_addr,
	output logic data_wen,
	output risc8_pkg::byte_t data_write
);
	// write lands at the end of the execute cycle
	assign wr_en = issue.write_reg;
	assign wr_idx = issue.rd;
	assign wr_data = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			sreg <= risc8_pkg::SREG_RESET;
			data_wen <= 1'b0;
		end else begin
			if (issue.update_flags)
				sreg <= next_sreg;
			// one cycle strobe per STS
			data_wen <= issue.store;
		end
	end

	// store payload, Rr comes through the ALU as MOVR
	always_ff @(posedge clk) begin
		if (issue.store) begin
			data_addr <= issue.store_addr;
			data_write <= result;
		end
	end
endmodule

`default_nettype wire

// ==== source/risc8_alu.sv ====
`default_nettype none

module risc8_alu (
	input risc8_pkg::byte_t rd_a,
	input risc8_pkg::byte_t rd_b,
	input risc8_pkg::sreg_t sreg,
	risc8_issue_if.exec issue,
	output risc8_pkg::byte_t result,
	output risc8_pkg::sreg_t next_sreg
);
	risc8_pkg::byte_t op_y;
	// subtract operands, NEG is 0 - Rd
	risc8_pkg::byte_t sub_x;
	risc8_pkg::byte_t sub_y;
	logic carry_in;
	logic [8:0] wide;
	logic [4:0] nib;
	logic set_nzs;
	logic shift_op;

	assign op_y = issue.use_const ? issue.const_value : rd_b;
	assign carry_in = issue.use_carry & sreg[risc8_pkg::SREG_C];
	assign sub_x = (issue.alu_op == risc8_pkg::NEG) ? 8'h00 : rd_a;
	assign sub_y = (issue.alu_op == risc8_pkg::NEG) ? rd_a : op_y;

	always_comb begin
		next_sreg = sreg;
		result = op_y;
		wide = '0;
		nib = '0;
		set_nzs = 1'b1;
		shift_op = 1'b0;

		case (issue.alu_op)
		risc8_pkg::ADD: begin
			wide = {1'b0, rd_a} + {1'b0, op_y} + 9'(carry_in);
			// half carry out of bit 3
			nib = {1'b0, rd_a[3:0]} + {1'b0, op_y[3:0]} + 5'(carry_in);
			result = wide[7:0];
			next_sreg[risc8_pkg::SREG_H] = nib[4];
			next_sreg[risc8_pkg::SREG_C] = wide[8];
			next_sreg[risc8_pkg::SREG_V] = (rd_a[7] & op_y[7] & ~result[7])
				| (~rd_a[7] & ~op_y[7] & result[7]);
		end
		risc8_pkg::SUB,
		risc8_pkg::NEG: begin
			// bit 8 and bit 4 come out as the borrows
			wide = {1'b0, sub_x} - {1'b0, sub_y} - 9'(carry_in);
			nib = {1'b0, sub_x[3:0]} - {1'b0, sub_y[3:0]} - 5'(carry_in);
			result = wide[7:0];
			next_sreg[risc8_pkg::SREG_H] = nib[4];
			// for NEG this is the same as result != 0
			next_sreg[risc8_pkg::SREG_C] = wide[8];
			next_sreg[risc8_pkg::SREG_V] = (sub_x[7] & ~sub_y[7] & ~result[7])
				| (~sub_x[7] & sub_y[7] & result[7]);
		end
		risc8_pkg::AND,
		risc8_pkg::OR,
		risc8_pkg::EOR: begin
			case (issue.alu_op)
			risc8_pkg::AND: result = rd_a & op_y;
			risc8_pkg::OR: result = rd_a | op_y;
			default: result = rd_a ^ op_y;
			endcase
			next_sreg[risc8_pkg::SREG_V] = 1'b0;
		end
		risc8_pkg::LSR,
		risc8_pkg::ROR,
		risc8_pkg::ASR: begin
			case (issue.alu_op)
			risc8_pkg::LSR: result = {1'b0, rd_a[7:1]};
			risc8_pkg::ROR: result = {sreg[risc8_pkg::SREG_C], rd_a[7:1]};
			default: result = {rd_a[7], rd_a[7:1]};
			endcase
			// bit shifted out goes to carry
			next_sreg[risc8_pkg::SREG_C] = rd_a[0];
			shift_op = 1'b1;
		end
		risc8_pkg::SWAP: begin
			result = {rd_a[3:0], rd_a[7:4]};
			set_nzs = 1'b0;
		end
		default: begin
			// MOVR, LDI and the STS data pass op_y through
			set_nzs = 1'b0;
		end
		endcase

		if (set_nzs) begin
			next_sreg[risc8_pkg::SREG_N] = result[7];
			// with sticky_z a zero byte only keeps an already set Z
			next_sreg[risc8_pkg::SREG_Z] = (result == 8'h00)
				& (~issue.sticky_z | sreg[risc8_pkg::SREG_Z]);
			if (shift_op)
				next_sreg[risc8_pkg::SREG_V] = result[7] ^ next_sreg[risc8_pkg::SREG_C];
			next_sreg[risc8_pkg::SREG_S] = next_sreg[risc8_pkg::SREG_N]
				^ next_sreg[risc8_pkg::SREG_V];
		end

		// no interrupts and no BST/BLD here
		next_sreg[risc8_pkg::SREG_T] = 1'b0;
		next_sreg[risc8_pkg::SREG_I] = 1'b0;
	end
endmodule

`default_nettype wire

// ==== source/risc8_regfile.sv ====
`default_nettype none

module risc8_regfile #(
	parameter int NUM_REGS = 32
) (
	input logic clk,
	input logic reset,
	input risc8_pkg::reg_idx_t ra,
	input risc8_pkg::reg_idx_t rb,
	output risc8_pkg::byte_t rd_a,
	output risc8_pkg::byte_t rd_b,
	input logic wr_en,
	input risc8_pkg::reg_idx_t wr_idx,
	input risc8_pkg::byte_t wr_data
);
	risc8_pkg::byte_t regs [NUM_REGS];
	logic wr_ok;

	// indices past a smaller file are dropped on write and read as zero
	assign wr_ok = wr_en && (int'(wr_idx) < NUM_REGS);

	// write first, a read of the index being written sees the new byte
	function automatic risc8_pkg::byte_t read_port(input risc8_pkg::reg_idx_t idx);
		if (wr_ok && wr_idx == idx)
			return wr_data;
		if (int'(idx) < NUM_REGS)
			return regs[idx];
		return '0;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
			rd_a <= '0;
			rd_b <= '0;
		end else begin
			if (wr_ok)
				regs[wr_idx] <= wr_data;
			rd_a <= read_port(ra);
			rd_b <= read_port(rb);
		end
	end
endmodule

`default_nettype wire

// ==== source/risc8_decode.sv ====
`default_nettype none

module risc8_decode (
	input logic clk,
	input logic reset,
	input risc8_pkg::opcode_t cdata,
	output risc8_pkg::pc_t pc,
	input risc8_pkg::sreg_t sreg,
	output risc8_pkg::reg_idx_t ra,
	output risc8_pkg::reg_idx_t rb,
	risc8_issue_if.issue issue
);
	risc8_pkg::seq_t seq;
	risc8_pkg::seq_t next_seq;
	risc8_pkg::pc_t next_pc;
	risc8_pkg::pc_t pc_inc;

	// first word of a two cycle instruction, kept for its second cycle
	risc8_pkg::opcode_t op_hold;
	risc8_pkg::opcode_t opcode;

	// opcode fields
	risc8_pkg::reg_idx_t op_rd;
	risc8_pkg::reg_idx_t op_rr;
	risc8_pkg::reg_idx_t op_rdi;
	risc8_pkg::byte_t op_k;
	risc8_pkg::pc_t simm12;
	risc8_pkg::pc_t simm7;
	logic branch_taken;

	// next issue contents
	risc8_pkg::alu_op_t alu_op;
	logic use_carry;
	logic sticky_z;
	logic use_const;
	risc8_pkg::byte_t const_value;
	risc8_pkg::reg_idx_t dest;
	logic write_reg;
	logic update_flags;
	logic store;

	assign opcode = (seq == risc8_pkg::SECOND) ? op_hold : cdata;
	assign pc_inc = pc + 16'd1;

	assign op_rd = opcode[8:4];
	assign op_rr = {opcode[9], opcode[3:0]};
	assign op_rdi = risc8_pkg::IMM_REG_BASE + risc8_pkg::reg_idx_t'(opcode[7:4]);
	assign op_k = {opcode[11:8], opcode[3:0]};
	assign simm12 = {{4{opcode[11]}}, opcode[11:0]};
	assign simm7 = {{9{opcode[9]}}, opcode[9:3]};

	// bit 10 clear is BRBS, set is BRBC
	assign branch_taken = sreg[opcode[2:0]] != opcode[10];

	always_comb begin
		// default is a bubble that reads Rd and Rr and moves on
		alu_op = risc8_pkg::MOVR;
		use_carry = 1'b0;
		sticky_z = 1'b0;
		use_const = 1'b0;
		const_value = op_k;
		dest = op_rd;
		write_reg = 1'b0;
		update_flags = 1'b0;
		store = 1'b0;
		ra = op_rd;
		rb = op_rr;
		next_pc = pc_inc;
		next_seq = risc8_pkg::FIRST;

		casez (opcode)
		16'b0000_01??_????_????: begin
			// CPC, flags only
			alu_op = risc8_pkg::SUB;
			use_carry = 1'b1;
			sticky_z = 1'b1;
			update_flags = 1'b1;
		end
		16'b0000_10??_????_????: begin
			// SBC
			alu_op = risc8_pkg::SUB;
			use_carry = 1'b1;
			sticky_z = 1'b1;
			update_flags = 1'b1;
			write_reg = 1'b1;
		end
		16'b0000_11??_????_????,
		16'b0001_11??_????_????: begin
			// ADD, ADC by bit 12 (LSL and ROL when Rd == Rr)
			alu_op = risc8_pkg::ADD;
			use_carry = opcode[12];
			update_flags = 1'b1;
			write_reg = 1'b1;
		end
		16'b0001_01??_????_????,
		16'b0001_10??_????_????: begin
			// CP and SUB share everything except the write
			alu_op = risc8_pkg::SUB;
			update_flags = 1'b1;
			write_reg = opcode[11];
		end
		16'b0010_00??_????_????,
		16'b0010_01??_????_????,
		16'b0010_10??_????_????: begin
			case (opcode[11:10])
			2'b00: alu_op = risc8_pkg::AND;
			2'b01: alu_op = risc8_pkg::EOR;
			default: alu_op = risc8_pkg::OR;
			endcase
			update_flags = 1'b1;
			write_reg = 1'b1;
		end
		16'b0010_11??_????_????: begin
			// MOV, no flags
			write_reg = 1'b1;
		end
		16'b0011_????_????_????,
		16'b0100_????_????_????,
		16'b0101_????_????_????,
		16'b0110_????_????_????,
		16'b0111_????_????_????: begin
			// CPI, SBCI, SUBI, ORI, ANDI on r16..r31 with K
			ra = op_rdi;
			dest = op_rdi;
			use_const = 1'b1;
			update_flags = 1'b1;
			write_reg = opcode[15:12] != 4'b0011;
			case (opcode[15:12])
			4'b0110: alu_op = risc8_pkg::OR;
			4'b0111: alu_op = risc8_pkg::AND;
			default: alu_op = risc8_pkg::SUB;
			endcase
			if (opcode[15:12] == 4'b0100) begin
				use_carry = 1'b1;
				sticky_z = 1'b1;
			end
		end
		16'b1110_????_????_????: begin
			// LDI passes K straight through
			dest = op_rdi;
			use_const = 1'b1;
			write_reg = 1'b1;
		end
		16'b1001_010?_????_0000: begin
			// COM as EOR with all ones
			alu_op = risc8_pkg::EOR;
			use_const = 1'b1;
			const_value = 8'hff;
			update_flags = 1'b1;
			write_reg = 1'b1;
		end
		16'b1001_010?_????_0001: begin
			alu_op = risc8_pkg::NEG;
			update_flags = 1'b1;
			write_reg = 1'b1;
		end
		16'b1001_010?_????_0010: begin
			// SWAP leaves SREG alone
			alu_op = risc8_pkg::SWAP;
			write_reg = 1'b1;
		end
		16'b1001_010?_????_0011,
		16'b1001_010?_????_1010: begin
			// INC and DEC as add or subtract of one
			alu_op = opcode[3] ? risc8_pkg::SUB : risc8_pkg::ADD;
			use_const = 1'b1;
			const_value = 8'h01;
			update_flags = 1'b1;
			write_reg = 1'b1;
		end
		16'b1001_010?_????_0101,
		16'b1001_010?_????_0110,
		16'b1001_010?_????_0111: begin
			case (opcode[1:0])
			2'b01: alu_op = risc8_pkg::ASR;
			2'b10: alu_op = risc8_pkg::LSR;
			default: alu_op = risc8_pkg::ROR;
			endcase
			update_flags = 1'b1;
			write_reg = 1'b1;
		end
		16'b1001_001?_????_0000: begin
			// STS k, Rr; source register sits in the Rd field
			rb = op_rd;
			if (seq == risc8_pkg::FIRST) begin
				// step onto the address word
				next_seq = risc8_pkg::SECOND;
			end else begin
				// cdata is the address, Rr read again for the execute cycle
				store = 1'b1;
			end
		end
		16'b1100_????_????_????: begin
			// RJMP
			next_pc = pc_inc + simm12;
		end
		16'b1111_0???_????_????: begin
			if (seq == risc8_pkg::FIRST) begin
				// hold one cycle so the prior instruction's flags land in SREG
				next_pc = pc;
				next_seq = risc8_pkg::SECOND;
			end else if (branch_taken) begin
				next_pc = pc_inc + simm7;
			end
		end
		default: begin
			// anything else runs as a NOP
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= risc8_pkg::PC_RESET;
			seq <= risc8_pkg::FIRST;
			issue.write_reg <= 1'b0;
			issue.update_flags <= 1'b0;
			issue.store <= 1'b0;
		end else begin
			pc <= next_pc;
			seq <= next_seq;
			issue.write_reg <= write_reg;
			issue.update_flags <= update_flags;
			issue.store <= store;
		end
	end

	always_ff @(posedge clk) begin
		if (seq == risc8_pkg::FIRST)
			op_hold <= cdata;
		issue.alu_op <= alu_op;
		issue.use_carry <= use_carry;
		issue.sticky_z <= sticky_z;
		issue.use_const <= use_const;
		issue.const_value <= const_value;
		issue.rd <= dest;
		// only meaningful in the STS second cycle
		issue.store_addr <= risc8_pkg::addr_t'(cdata);
	end
endmodule

`default_nettype wire

// ==== source/risc8_issue_if.sv ====
`default_nettype none

// one decoded instruction, handed from decode to the ALU and the result stage
interface risc8_issue_if;
	risc8_pkg::alu_op_t alu_op;
	// ADC, SBC, SBCI and CPC pull in the old carry
	logic use_carry;
	// CPC and SBC style Z, only stays set if it already was
	logic sticky_z;
	logic use_const;
	risc8_pkg::byte_t const_value;
	risc8_pkg::reg_idx_t rd;
	logic write_reg;
	logic update_flags;
	// STS data cycle
	logic store;
	risc8_pkg::addr_t store_addr;

	modport issue (
		output alu_op, use_carry, sticky_z, use_const, const_value,
		output rd, write_reg, update_flags, store, store_addr
	);
	modport exec (input alu_op, use_carry, sticky_z, use_const, const_value);
	modport retire (input rd, write_reg, update_flags, store, store_addr);
endinterface

`default_nettype wire

// ==== source/risc8_pkg.sv ====
`default_nettype none

package risc8_pkg;

	// one register or data byte
	typedef logic [7:0] byte_t;

	// register number, r0 to r31
	typedef logic [4:0] reg_idx_t;

	// program memory is word addressed
	typedef logic [15:0] pc_t;

	// data space address for STS
	typedef logic [15:0] addr_t;

	// one instruction word from the program ROM
	typedef logic [15:0] opcode_t;

	// status register, AVR bit order
	typedef logic [7:0] sreg_t;

	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;
	localparam int SREG_N = 2;
	localparam int SREG_V = 3;
	localparam int SREG_S = 4;
	localparam int SREG_H = 5;
	localparam int SREG_T = 6;
	localparam int SREG_I = 7;

	// functions of the ALU
	// COM, INC and DEC are folded into EOR, ADD and SUB with a constant
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		EOR,
		MOVR,
		NEG,
		SWAP,
		LSR,
		ROR,
		ASR
	} alu_op_t;

	// decode sequencing, second cycle only for branches and STS
	typedef enum logic {
		FIRST,
		SECOND
	} seq_t;

	localparam pc_t PC_RESET = 16'h0000;
	localparam sreg_t SREG_RESET = 8'h00;

	// LDI and the other immediate ops reach r16..r31 only
	localparam reg_idx_t IMM_REG_BASE = 5'd16;

endpackage

`default_nettype wire
